//--- Bender.yml
package:
  name: tcp_tx

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tcp_tx_pkg.sv
      - rtl/tcp_tx_buf.sv
      - rtl/tcp_tx_segmenter.sv
      - rtl/tcp_tx_info_table.sv
      - rtl/tcp_tx_scanner.sv
      - rtl/tcp_tx_streamer.sv
      - rtl/tcp_tx_ctl.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tcp_tx_ctl_sva.sv
      - tb/tcp_tx_ctl_tb.sv

//--- flist.f
+incdir+rtl
rtl/tcp_tx_pkg.sv
rtl/tcp_tx_buf.sv
rtl/tcp_tx_segmenter.sv
rtl/tcp_tx_info_table.sv
rtl/tcp_tx_scanner.sv
rtl/tcp_tx_streamer.sv
rtl/tcp_tx_ctl.sv
tb/tcp_tx_ctl_sva.sv
tb/tcp_tx_ctl_tb.sv

//--- rtl/tcp_tx_buf.sv
`timescale 1ns/1ps
`include "tcp_tx_defines.svh"

module tcp_tx_buf (
  input  logic              clk,
  input  logic              reset,
  input  logic              wr_en,
  input  tcp_tx_pkg::byte_t wr_data,
  input  tcp_tx_pkg::seq_t  wr_seq,
  input  tcp_tx_pkg::seq_t  free_seq,
  input  tcp_tx_pkg::seq_t  rd_addr,
  output tcp_tx_pkg::byte_t rd_data,
  output logic              full
);

  localparam int DEPTH = 2 ** `TCP_BUF_AW;

  tcp_tx_pkg::byte_t mem [DEPTH];
  tcp_tx_pkg::seq_t  fill; // bytes held once this cycle's write lands

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_seq[`TCP_BUF_AW-1:0]] <= wr_data; // byte sits at its own seq
    rd_data <= mem[rd_addr[`TCP_BUF_AW-1:0]]; // one cycle read latency
  end

  ////////////////////
  // fill level
  ////////////////////

  // distance from the free point to the write point, looking one write ahead
  // so full is already up in the cycle the last free slot gets used
  assign fill = wr_seq + wr_en - free_seq;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else begin
      // free_seq may move forward meanwhile, that only makes this conservative
      full <= (fill >= DEPTH);
    end
  end

endmodule

//--- rtl/tcp_tx_ctl.sv
`timescale 1ns/1ps
`include "tcp_tx_defines.svh"

module tcp_tx_ctl (
  input  logic              clk,
  input  logic              reset,
  input  logic              connected,
  input  logic              init,
  input  tcp_tx_pkg::seq_t  init_seq,
  input  logic              data_val,
  input  tcp_tx_pkg::byte_t data_dat,
  input  logic              data_snd,
  output logic              cts,
  input  tcp_tx_pkg::seq_t  rem_ack,
  input  logic              req,
  input  logic              sent,
  output logic              send,
  output tcp_tx_pkg::seq_t  pld_start,
  output tcp_tx_pkg::seq_t  pld_stop,
  output tcp_tx_pkg::len_t  pld_len,
  output tcp_tx_pkg::cks_t  pld_cks,
  output logic              strm_val,
  output logic              strm_sof,
  output logic              strm_eof,
  output tcp_tx_pkg::byte_t strm_dat,
  output tcp_tx_pkg::seq_t  last_seq,
  output tcp_tx_pkg::seq_t  loc_seq,
  output logic              force_dcn
);

  // buffer
  logic                   buf_full;
  tcp_tx_pkg::seq_t       free_seq, rd_addr;
  tcp_tx_pkg::byte_t      rd_data;
  // descriptor write
  logic                   add_en;
  logic [`TCP_PKT_AW-1:0] add_addr;
  logic [`TCP_PKT_AW:0]   add_count;
  tcp_tx_pkg::seq_t       add_start, add_stop;
  tcp_tx_pkg::len_t       add_len;
  tcp_tx_pkg::cks_t       add_cks;
  // scanner port
  logic                   upd_en, upd_exists, q_exists;
  logic [`TCP_PKT_AW-1:0] upd_addr;
  tcp_tx_pkg::tries_t     upd_tries, q_tries;
  tcp_tx_pkg::rto_t       upd_rto, q_rto;
  tcp_tx_pkg::seq_t       q_start, q_stop;
  tcp_tx_pkg::len_t       q_len;
  tcp_tx_pkg::cks_t       q_cks;
  // hand-off to the streamer
  logic                   tx_go, tx_idle, ring_full;
  tcp_tx_pkg::seq_t       go_start, go_stop;
  tcp_tx_pkg::len_t       go_len;
  tcp_tx_pkg::cks_t       go_cks;

  assign cts = connected && !ring_full && !buf_full; // user back-pressure

  ////////////////////
  // blocks
  ////////////////////

  tcp_tx_buf u_buf (
    .clk(clk), .reset(reset),
    .wr_en(data_val), .wr_data(data_dat), .wr_seq(loc_seq), // byte lands at current seq
    .free_seq(free_seq), .rd_addr(rd_addr), .rd_data(rd_data), .full(buf_full)
  );

  tcp_tx_segmenter u_seg (
    .clk(clk), .reset(reset), .init(init), .init_seq(init_seq),
    .data_val(data_val), .data_snd(data_snd), .data_dat(data_dat), .buf_full(buf_full),
    .loc_seq(loc_seq), .add_en(add_en), .add_addr(add_addr),
    .add_start(add_start), .add_stop(add_stop), .add_len(add_len), .add_cks(add_cks),
    .add_count(add_count)
  );

  tcp_tx_info_table u_table (
    .clk(clk), .reset(reset),
    .add_en(add_en), .add_addr(add_addr), .add_start(add_start), .add_stop(add_stop),
    .add_len(add_len), .add_cks(add_cks),
    .upd_en(upd_en), .upd_addr(upd_addr), .upd_exists(upd_exists),
    .upd_tries(upd_tries), .upd_rto(upd_rto),
    .q_start(q_start), .q_stop(q_stop), .q_len(q_len), .q_cks(q_cks),
    .q_exists(q_exists), .q_tries(q_tries), .q_rto(q_rto)
  );

  tcp_tx_scanner u_scan (
    .clk(clk), .reset(reset), .init(init), .init_seq(init_seq), .rem_ack(rem_ack),
    .add_en(add_en), .add_count(add_count), .tx_idle(tx_idle),
    .upd_en(upd_en), .upd_addr(upd_addr), .upd_exists(upd_exists),
    .upd_tries(upd_tries), .upd_rto(upd_rto),
    .q_start(q_start), .q_stop(q_stop), .q_len(q_len), .q_cks(q_cks),
    .q_exists(q_exists), .q_tries(q_tries), .q_rto(q_rto),
    .tx_go(tx_go), .go_start(go_start), .go_stop(go_stop), .go_len(go_len),
    .go_cks(go_cks), .free_seq(free_seq), .ring_full(ring_full), .force_dcn(force_dcn)
  );

  tcp_tx_streamer u_strm (
    .clk(clk), .reset(reset), .init(init), .init_seq(init_seq),
    .tx_go(tx_go), .go_start(go_start), .go_stop(go_stop), .go_len(go_len),
    .go_cks(go_cks), .req(req), .sent(sent), .rd_data(rd_data), .rd_addr(rd_addr),
    .tx_idle(tx_idle), .send(send),
    .pld_start(pld_start), .pld_stop(pld_stop), .pld_len(pld_len), .pld_cks(pld_cks),
    .strm_val(strm_val), .strm_sof(strm_sof), .strm_eof(strm_eof), .strm_dat(strm_dat),
    .last_seq(last_seq)
  );

endmodule

//--- rtl/tcp_tx_defines.svh
`ifndef TCP_TX_DEFINES_SVH
`define TCP_TX_DEFINES_SVH

////////////////////
// buffer sizing
////////////////////

// byte buffer holds 2**8 = 256 bytes, indexed by low seq bits
`define TCP_BUF_AW 8

// descriptor ring holds 2**2 = 4 segments
`define TCP_PKT_AW 2

////////////////////
// segmentation
////////////////////

`define TCP_MAX_PLD 16 // payload bytes per segment, stands in for mtu minus headers
`define TCP_WAIT_TICKS 8 // idle cycles before an open segment is closed

////////////////////
// retransmission
////////////////////

`define TCP_RTX_TICKS 64 // scanner visits before an unacked segment goes out again
`define TCP_RTX_TRIES 4 // transmissions that force a disconnect

`endif

//--- rtl/tcp_tx_info_table.sv
`timescale 1ns/1ps
`include "tcp_tx_defines.svh"

module tcp_tx_info_table (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   add_en,
  input  logic [`TCP_PKT_AW-1:0] add_addr,
  input  tcp_tx_pkg::seq_t       add_start,
  input  tcp_tx_pkg::seq_t       add_stop,
  input  tcp_tx_pkg::len_t       add_len,
  input  tcp_tx_pkg::cks_t       add_cks,
  input  logic                   upd_en,
  input  logic [`TCP_PKT_AW-1:0] upd_addr,
  input  logic                   upd_exists,
  input  tcp_tx_pkg::tries_t     upd_tries,
  input  tcp_tx_pkg::rto_t       upd_rto,
  output tcp_tx_pkg::seq_t       q_start,
  output tcp_tx_pkg::seq_t       q_stop,
  output tcp_tx_pkg::len_t       q_len,
  output tcp_tx_pkg::cks_t       q_cks,
  output logic                   q_exists,
  output tcp_tx_pkg::tries_t     q_tries,
  output tcp_tx_pkg::rto_t       q_rto
);

  localparam int DEPTH = 2 ** `TCP_PKT_AW;

  tcp_tx_pkg::seq_t   start_mem [DEPTH];
  tcp_tx_pkg::seq_t   stop_mem  [DEPTH];
  tcp_tx_pkg::len_t   len_mem   [DEPTH];
  tcp_tx_pkg::cks_t   cks_mem   [DEPTH];
  tcp_tx_pkg::tries_t tries_mem [DEPTH];
  tcp_tx_pkg::rto_t   rto_mem   [DEPTH];
  logic [DEPTH-1:0]   exists;

  // valid flags, add wins on a shared address
  always_ff @(posedge clk) begin
    if (reset) begin
      exists <= '0;
    end else begin
      if (upd_en) exists[upd_addr] <= upd_exists;
      if (add_en) exists[add_addr] <= 1'b1;
    end
  end

  ////////////////////
  // field storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (upd_en) begin
      tries_mem[upd_addr] <= upd_tries;
      rto_mem[upd_addr]   <= upd_rto;
    end
    if (add_en) begin
      start_mem[add_addr] <= add_start;
      stop_mem[add_addr]  <= add_stop;
      len_mem[add_addr]   <= add_len;
      cks_mem[add_addr]   <= add_cks;
      tries_mem[add_addr] <= '0; // never sent
      rto_mem[add_addr]   <= '0;
    end
  end

  // scanner read port, registered
  always_ff @(posedge clk) begin
    q_start  <= start_mem[upd_addr];
    q_stop   <= stop_mem[upd_addr];
    q_len    <= len_mem[upd_addr];
    q_cks    <= cks_mem[upd_addr];
    q_exists <= exists[upd_addr];
    q_tries  <= tries_mem[upd_addr];
    q_rto    <= rto_mem[upd_addr];
  end

endmodule

//--- rtl/tcp_tx_pkg.sv
package tcp_tx_pkg;

  ////////////////////
  // widths
  ////////////////////

  typedef logic [31:0] seq_t; // sequence number
  typedef logic [7:0] byte_t; // payload byte
  typedef logic [15:0] len_t; // segment length in bytes
  typedef logic [31:0] cks_t; // unfolded ones complement sum of 16 bit words
  typedef logic [2:0] tries_t; // transmission count
  typedef logic [7:0] rto_t; // timer count

  ////////////////////
  // fsm states
  ////////////////////

  // segment builder, idle or collecting bytes
  typedef enum logic {seg_idle, seg_pend} seg_state_t;

  // one state per cycle of a table visit
  typedef enum logic [2:0] {
    scan_read,
    scan_judge,
    scan_choose,
    scan_update,
    scan_next
  } scan_state_t;

  typedef enum logic [1:0] {tx_idle, tx_wait, tx_on, tx_done} tx_state_t;

endpackage

//--- rtl/tcp_tx_scanner.sv
`timescale 1ns/1ps
`include "tcp_tx_defines.svh"

module tcp_tx_scanner (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   init,
  input  tcp_tx_pkg::seq_t       init_seq,
  input  tcp_tx_pkg::seq_t       rem_ack,
  input  logic                   add_en,
  input  logic [`TCP_PKT_AW:0]   add_count,
  input  logic                   tx_idle,
  output logic                   upd_en,
  output logic [`TCP_PKT_AW-1:0] upd_addr,
  output logic                   upd_exists,
  output tcp_tx_pkg::tries_t     upd_tries,
  output tcp_tx_pkg::rto_t       upd_rto,
  input  tcp_tx_pkg::seq_t       q_start,
  input  tcp_tx_pkg::seq_t       q_stop,
  input  tcp_tx_pkg::len_t       q_len,
  input  tcp_tx_pkg::cks_t       q_cks,
  input  logic                   q_exists,
  input  tcp_tx_pkg::tries_t     q_tries,
  input  tcp_tx_pkg::rto_t       q_rto,
  output logic                   tx_go,
  output tcp_tx_pkg::seq_t       go_start,
  output tcp_tx_pkg::seq_t       go_stop,
  output tcp_tx_pkg::len_t       go_len,
  output tcp_tx_pkg::cks_t       go_cks,
  output tcp_tx_pkg::seq_t       free_seq,
  output logic                   ring_full,
  output logic                   force_dcn
);

  tcp_tx_pkg::scan_state_t state;
  logic [`TCP_PKT_AW-1:0]  upd_ptr;  // entry under visit
  logic [`TCP_PKT_AW-1:0]  next_ptr; // next entry for a first send
  logic [`TCP_PKT_AW:0]    rem_ptr;  // oldest entry still held
  logic [`TCP_PKT_AW:0]    used;
  tcp_tx_pkg::seq_t        ack_dif;
  tcp_tx_pkg::tries_t      e_tries;
  tcp_tx_pkg::rto_t        e_rto;
  logic                    e_exists, acked, free, go, collide, in_upd;

  assign upd_addr = upd_ptr;
  assign ack_dif  = rem_ack - q_stop; // msb clear means fully acked
  assign used     = add_count - rem_ptr;
  // one slot stays spare for a segment still being built
  assign ring_full = (used >= (`TCP_PKT_AW+1)'(2 ** `TCP_PKT_AW - 1));

  ////////////////////
  // update port
  ////////////////////

  assign collide    = add_en && (add_count[`TCP_PKT_AW-1:0] == upd_ptr);
  assign in_upd     = (state == tcp_tx_pkg::scan_update) && !collide;
  assign upd_en     = in_upd && e_exists; // empty slots are left alone
  assign tx_go      = in_upd && go;
  assign upd_exists = !free;
  assign upd_tries  = go ? e_tries + 1'b1 : e_tries;
  always_comb begin
    upd_rto = e_rto;
    if (go) upd_rto = '0; // timer restarts with every send
    else if (e_tries != 0 && e_rto != `TCP_RTX_TICKS) upd_rto = e_rto + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset || init) begin
      state     <= tcp_tx_pkg::scan_read;
      upd_ptr   <= '0;
      next_ptr  <= '0;
      rem_ptr   <= '0;
      free      <= 1'b0;
      go        <= 1'b0;
      force_dcn <= 1'b0;
      free_seq  <= reset ? '0 : init_seq;
    end else begin
      case (state)
        tcp_tx_pkg::scan_read: state <= tcp_tx_pkg::scan_judge; // table read in flight
        tcp_tx_pkg::scan_judge: begin
          go_start <= q_start; // latch the entry for the rest of the visit
          go_stop  <= q_stop;
          go_len   <= q_len;
          go_cks   <= q_cks;
          e_exists <= q_exists;
          e_tries  <= q_tries;
          e_rto    <= q_rto;
          acked    <= q_exists && !ack_dif[31];
          state    <= tcp_tx_pkg::scan_choose;
        end
        tcp_tx_pkg::scan_choose: begin
          free <= acked && (upd_ptr == rem_ptr[`TCP_PKT_AW-1:0]); // oldest only
          go   <= e_exists && !acked && tx_idle && (e_tries != `TCP_RTX_TRIES) &&
                  ((e_tries == 0 && upd_ptr == next_ptr) ||     // first send, in order
                   (e_tries != 0 && e_rto == `TCP_RTX_TICKS));  // timer expired
          if (e_exists && e_tries == `TCP_RTX_TRIES) force_dcn <= 1'b1; // sticky
          state <= tcp_tx_pkg::scan_update;
        end
        tcp_tx_pkg::scan_update: begin
          if (!collide) begin
            if (free) begin
              rem_ptr  <= rem_ptr + 1'b1;
              free_seq <= go_stop; // buffer space up to here is released
            end
            if (go && e_tries == 0) next_ptr <= upd_ptr + 1'b1;
          end
          state <= tcp_tx_pkg::scan_next;
        end
        default: begin // scan_next
          upd_ptr <= upd_ptr + 1'b1;
          free    <= 1'b0;
          go      <= 1'b0;
          state   <= tcp_tx_pkg::scan_read;
        end
      endcase
    end
  end

endmodule

//--- rtl/tcp_tx_segmenter.sv
`timescale 1ns/1ps
`include "tcp_tx_defines.svh"

module tcp_tx_segmenter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   init,
  input  tcp_tx_pkg::seq_t       init_seq,
  input  logic                   data_val,
  input  logic                   data_snd,
  input  tcp_tx_pkg::byte_t      data_dat,
  input  logic                   buf_full,
  output tcp_tx_pkg::seq_t       loc_seq,
  output logic                   add_en,
  output logic [`TCP_PKT_AW-1:0] add_addr,
  output tcp_tx_pkg::seq_t       add_start,
  output tcp_tx_pkg::seq_t       add_stop,
  output tcp_tx_pkg::len_t       add_len,
  output tcp_tx_pkg::cks_t       add_cks,
  output logic [`TCP_PKT_AW:0]   add_count
);

  tcp_tx_pkg::seg_state_t state;
  tcp_tx_pkg::len_t       cnt;   // bytes in the open segment
  tcp_tx_pkg::cks_t       cks;   // sum of completed word pairs
  tcp_tx_pkg::byte_t      prev;  // last byte, high half of the next word
  tcp_tx_pkg::rto_t       idle;  // cycles since the last byte
  tcp_tx_pkg::seq_t       start; // seq of the first byte
  logic                   close;

  // any of the four end conditions, only while a segment is open
  assign close = (state == tcp_tx_pkg::seg_pend) &&
                 ((data_val && cnt == `TCP_MAX_PLD - 1) || // this byte fills it
                  (!data_val && idle == `TCP_WAIT_TICKS) ||
                  data_snd || buf_full);

  ////////////////////
  // descriptor fields
  ////////////////////

  // valid in the add_en cycle, registers still hold the closed segment
  assign add_addr  = add_count[`TCP_PKT_AW-1:0];
  assign add_start = start;
  assign add_stop  = loc_seq; // one past the last byte, the expected ack
  assign add_len   = cnt;
  assign add_cks   = cnt[0] ? cks + {prev, 8'h00} : cks; // odd tail padded with zero

  // local sequence tracker
  always_ff @(posedge clk) begin
    if (reset) begin
      loc_seq <= '0;
    end else if (init) begin
      loc_seq <= init_seq;
    end else if (data_val) begin
      loc_seq <= loc_seq + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || init) begin
      state     <= tcp_tx_pkg::seg_idle;
      add_en    <= 1'b0;
      add_count <= '0;
    end else begin
      add_en <= close; // descriptor write one cycle after close
      if (add_en) add_count <= add_count + 1'b1;
      case (state)
        tcp_tx_pkg::seg_idle: if (data_val) state <= tcp_tx_pkg::seg_pend;
        tcp_tx_pkg::seg_pend: if (close) state <= tcp_tx_pkg::seg_idle;
        default:              state <= tcp_tx_pkg::seg_idle;
      endcase
    end
  end

  // byte count, checksum and idle timer
  always_ff @(posedge clk) begin
    if (data_val) prev <= data_dat;
    if (state == tcp_tx_pkg::seg_idle) begin
      start <= loc_seq; // seq of a byte arriving now
      cnt   <= data_val ? 16'd1 : 16'd0;
      cks   <= '0;
      idle  <= '0;
    end else begin
      if (data_val) begin
        cnt <= cnt + 1'b1;
        if (cnt[0]) cks <= cks + {prev, data_dat}; // big endian word complete
      end
      idle <= data_val ? '0 : idle + 1'b1;
    end
  end

endmodule

//--- rtl/tcp_tx_streamer.sv
`timescale 1ns/1ps

module tcp_tx_streamer (
  input  logic               clk,
  input  logic               reset,
  input  logic               init,
  input  tcp_tx_pkg::seq_t   init_seq,
  input  logic               tx_go,
  input  tcp_tx_pkg::seq_t   go_start,
  input  tcp_tx_pkg::seq_t   go_stop,
  input  tcp_tx_pkg::len_t   go_len,
  input  tcp_tx_pkg::cks_t   go_cks,
  input  logic               req,
  input  logic               sent,
  input  tcp_tx_pkg::byte_t  rd_data,
  output tcp_tx_pkg::seq_t   rd_addr,
  output logic               tx_idle,
  output logic               send,
  output tcp_tx_pkg::seq_t   pld_start,
  output tcp_tx_pkg::seq_t   pld_stop,
  output tcp_tx_pkg::len_t   pld_len,
  output tcp_tx_pkg::cks_t   pld_cks,
  output logic               strm_val,
  output logic               strm_sof,
  output logic               strm_eof,
  output tcp_tx_pkg::byte_t  strm_dat,
  output tcp_tx_pkg::seq_t   last_seq
);

  tcp_tx_pkg::tx_state_t state;
  tcp_tx_pkg::len_t      cnt;      // bytes put out so far
  tcp_tx_pkg::seq_t      stop_dif;

  assign tx_idle  = (state == tcp_tx_pkg::tx_idle);
  assign strm_dat = rd_data; // buffer output lines up with strm_val
  assign stop_dif = pld_stop - last_seq; // msb clear when the stop is ahead

  always_ff @(posedge clk) begin
    if (reset || init) begin
      state    <= tcp_tx_pkg::tx_idle;
      send     <= 1'b0;
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      strm_eof <= 1'b0;
      cnt      <= '0;
      last_seq <= reset ? '0 : init_seq;
    end else begin
      case (state)
        tcp_tx_pkg::tx_idle: if (tx_go) begin
          pld_start <= go_start;
          pld_stop  <= go_stop;
          pld_len   <= go_len;
          pld_cks   <= go_cks;
          rd_addr   <= go_start; // first byte already being read
          send      <= 1'b1;
          state     <= tcp_tx_pkg::tx_wait;
        end
        tcp_tx_pkg::tx_wait: if (req) begin
          send     <= 1'b0;
          strm_val <= 1'b1;
          strm_sof <= 1'b1;
          strm_eof <= (pld_len == 16'd1);
          cnt      <= 16'd1;
          rd_addr  <= rd_addr + 1'b1;
          state    <= tcp_tx_pkg::tx_on;
        end
        tcp_tx_pkg::tx_on: begin
          strm_sof <= 1'b0;
          if (strm_eof) begin
            strm_val <= 1'b0;
            strm_eof <= 1'b0;
            state    <= tcp_tx_pkg::tx_done;
          end else begin
            cnt      <= cnt + 1'b1;
            strm_eof <= (cnt == pld_len - 1'b1); // next byte is the last
            rd_addr  <= rd_addr + 1'b1;
          end
        end
        default: if (sent) begin // tx_done, engine has the whole segment
          if (!stop_dif[31]) last_seq <= pld_stop; // never step back on a resend
          state <= tcp_tx_pkg::tx_idle;
        end
      endcase
    end
  end

endmodule

//--- tb/tcp_tx_ctl_sva.sv
`timescale 1ns/1ps

module tcp_tx_ctl_sva (
  input logic clk,
  input logic reset,
  input logic init,
  input logic send,
  input logic strm_val,
  input logic strm_sof,
  input logic strm_eof,
  input logic force_dcn
);

  ////////////////////
  // stream framing
  ////////////////////

  assert property (@(posedge clk) disable iff (reset) strm_sof |-> strm_val)
    else $error("strm_sof without strm_val");
  assert property (@(posedge clk) disable iff (reset) strm_eof |-> strm_val)
    else $error("strm_eof without strm_val");

  // offer phase and payload phase never overlap
  assert property (@(posedge clk) disable iff (reset) !(send && strm_val))
    else $error("send and strm_val high together");

  // disconnect stays up until reset or init
  assert property (@(posedge clk) $fell(force_dcn) |-> $past(reset) || $past(init))
    else $error("force_dcn fell without reset or init");

endmodule

bind tcp_tx_ctl tcp_tx_ctl_sva u_sva (
  .clk(clk), .reset(reset), .init(init), .send(send), .strm_val(strm_val),
  .strm_sof(strm_sof), .strm_eof(strm_eof), .force_dcn(force_dcn)
);

//--- tb/tcp_tx_ctl_tb.sv
`timescale 1ns/1ps
`include "tcp_tx_defines.svh"

module tcp_tx_ctl_tb;

  logic              clk, reset, connected, init, data_val, data_snd, req, sent;
  tcp_tx_pkg::seq_t  init_seq, rem_ack, pld_start, pld_stop, last_seq, loc_seq;
  tcp_tx_pkg::byte_t data_dat, strm_dat;
  tcp_tx_pkg::len_t  pld_len;
  tcp_tx_pkg::cks_t  pld_cks;
  logic              cts, send, strm_val, strm_sof, strm_eof, force_dcn;

  logic [15:0]       lfsr = 16'd61; // seed
  tcp_tx_pkg::byte_t stream_q [$]; // every accepted byte, base_seq first
  tcp_tx_pkg::seq_t  base_seq, next_start, ack_q [$];
  tcp_tx_pkg::seq_t  seg_start [$], seg_stop [$]; // descriptors seen so far
  tcp_tx_pkg::len_t  seg_len [$];
  tcp_tx_pkg::cks_t  seg_cks [$];
  int                seg_tx [$]; // transmissions per descriptor
  int                mismatches, timeouts, eng, eng_wait, req_delay, byte_idx, cur;
  int                gap, ack_age, max_tx, n, target;

  tcp_tx_ctl dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? (s >> 1) ^ 16'hB400 : s >> 1; // galois, taps 16 14 13 11
  endfunction

  function automatic logic [31:0] take_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      r    = {r[30:0], lfsr[0]}; // one step per bit
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout: %s at %0t", what, $time);
  endtask

  // big endian word sum, odd tail byte padded low
  function automatic tcp_tx_pkg::cks_t payload_sum(input tcp_tx_pkg::seq_t start, input int len);
    tcp_tx_pkg::cks_t sum;
    tcp_tx_pkg::seq_t ofs;
    sum = '0;
    for (int i = 0; i < len; i++) begin
      ofs = start - base_seq + i;
      sum += (i % 2 == 0) ? {16'h0, stream_q[ofs], 8'h00} : {24'h0, stream_q[ofs]};
    end
    return sum;
  endfunction

  function automatic int find_seg(input tcp_tx_pkg::seq_t start);
    for (int i = seg_start.size() - 1; i >= 0; i--)
      if (seg_start[i] == start) return i;
    return -1;
  endfunction

  ////////////////////
  // engine model
  ////////////////////

  task automatic take_descriptor();
    tcp_tx_pkg::seq_t dif;
    dif = rem_ack - pld_stop;
    if (ack_age > 8) check("pld_stop covered by rem_ack", !dif[31], 1'b0); // ack has settled
    check("pld_len", pld_len, pld_stop - pld_start);
    check("pld_len in range", pld_len >= 1 && pld_len <= `TCP_MAX_PLD, 1'b1);
    check("pld_cks", pld_cks,
          payload_sum(pld_start, (pld_len > `TCP_MAX_PLD) ? `TCP_MAX_PLD : pld_len));
    cur = find_seg(pld_start);
    if (cur < 0) begin
      check("pld_start", pld_start, next_start); // first sends follow on without gap
      seg_start.push_back(pld_start);
      seg_stop.push_back(pld_stop);
      seg_len.push_back(pld_len);
      seg_cks.push_back(pld_cks);
      seg_tx.push_back(1);
      ack_q.push_back(pld_stop);
      next_start = pld_stop;
      cur        = seg_start.size() - 1;
    end else begin
      check("pld_stop resend", pld_stop, seg_stop[cur]); // resend must repeat the original
      check("pld_len resend", pld_len, seg_len[cur]);
      check("pld_cks resend", pld_cks, seg_cks[cur]);
      seg_tx[cur]++;
      check("transmissions within limit", seg_tx[cur] <= `TCP_RTX_TRIES, 1'b1);
      if (seg_tx[cur] > max_tx) max_tx = seg_tx[cur];
    end
  endtask

  task automatic engine_step();
    tcp_tx_pkg::seq_t ofs;
    eng_wait++;
    case (eng)
      0: begin
        eng_wait = 0;
        if (send) begin
          take_descriptor();
          req_delay = take_bits(3); // engine latency before it asks for payload
          eng       = 1;
        end
      end
      1: if (req_delay == 0) begin
        req      = 1'b1;
        byte_idx = 0;
        eng      = 2;
      end else begin
        req_delay--;
      end
      2: begin
        req = 1'b0;
        if (strm_val) begin
          ofs = seg_start[cur] - base_seq + byte_idx;
          check("strm_dat", strm_dat, stream_q[ofs]);
          check("strm_sof", strm_sof, byte_idx == 0);
          check("strm_eof", strm_eof, byte_idx == seg_len[cur] - 1);
          byte_idx++;
          if (strm_eof) begin
            check("streamed byte count", byte_idx, seg_len[cur]);
            eng = 3;
          end
        end
      end
      3: begin
        sent = 1'b1; // streamer sits in its done state by now
        eng  = 4;
      end
      default: begin
        sent = 1'b0;
        check("last_seq", last_seq, next_start); // highest stop handed over
        eng  = 0;
      end
    endcase
    if (eng_wait > 200 && timeouts == 0) note_timeout($sformatf("engine stalled in step %0d", eng));
  endtask

  ////////////////////
  // user side
  ////////////////////

  task automatic tick(input bit writing, input bit acking);
    @(negedge clk);
    engine_step();
    if (ack_age < 1000) ack_age++;
    check("loc_seq", loc_seq, base_seq + stream_q.size()); // one step per accepted byte
    data_val = 1'b0;
    data_snd = 1'b0;
    if (acking && ack_q.size() != 0 && take_bits(3) == 0) begin
      rem_ack = ack_q.pop_front(); // whole segments only
      ack_age = 0;
    end
    if (writing) begin
      if (gap != 0) begin
        gap--;
      end else if (cts && take_bits(2) != 0) begin
        data_val = 1'b1;
        data_dat = take_bits(8);
        stream_q.push_back(data_dat);
        data_snd = (take_bits(4) == 0);
        if (take_bits(5) == 0) gap = take_bits(4); // long gaps hit the idle close
      end
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  ////////////////////
  // sequence
  ////////////////////

  initial begin
    reset     = 1'b1;
    connected = 1'b0;
    init      = 1'b0;
    init_seq  = '0;
    data_val  = 1'b0;
    data_dat  = '0;
    data_snd  = 1'b0;
    rem_ack   = '0;
    req       = 1'b0;
    sent      = 1'b0;
    mismatches = 0;
    timeouts   = 0;
    eng        = 0;
    eng_wait   = 0;
    gap        = 0;
    ack_age    = 0;
    max_tx     = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (3) begin // quiet and blocked while not connected
      @(negedge clk);
      check("send", send, 1'b0);
      check("strm_val", strm_val, 1'b0);
      check("force_dcn", force_dcn, 1'b0);
      check("cts", cts, 1'b0);
    end
    init_seq   = take_bits(32);
    base_seq   = init_seq;
    next_start = init_seq;
    rem_ack    = init_seq; // nothing acked yet
    init       = 1'b1;
    connected  = 1'b1;
    @(negedge clk);
    init = 1'b0;
    check("loc_seq after init", loc_seq, init_seq);
    check("cts after connect", cts, 1'b1);

    // random traffic with acks following the sends
    n = 0;
    while (stream_q.size() < 1200 && n < 40000 && timeouts == 0) begin
      tick(1'b1, 1'b1);
      n++;
    end
    if (n >= 40000) note_timeout("user data phase did not finish");

    // drain, then ack everything
    n = 0;
    while (next_start != base_seq + stream_q.size() && n < 5000 && timeouts == 0) begin
      tick(1'b0, 1'b0);
      n++;
    end
    if (n >= 5000) note_timeout("not all written bytes were sent");
    rem_ack = next_start;
    ack_age = 0;
    n = 0;
    while (!cts && n < 500 && timeouts == 0) begin
      tick(1'b0, 1'b0);
      n++;
    end
    if (n >= 500) note_timeout("cts stayed low after the full ack");
    for (int i = 0; i < 300 && timeouts == 0; i++) tick(1'b0, 1'b0); // nothing may go out again
    check("last_seq after ack", last_seq, next_start);

    // no more acks, resends until disconnect
    target = stream_q.size() + 60;
    n = 0;
    while (!force_dcn && n < 30000 && timeouts == 0) begin
      tick(stream_q.size() < target, 1'b0);
      n++;
    end
    if (n >= 30000) note_timeout("force_dcn did not rise without acks");
    check("resend seen", max_tx >= 2, 1'b1);
    finish_run();
  end

endmodule
